// ==== rtl/csr_pkg.sv ====
package csr_pkg;

    typedef enum logic [13:0] {
        CRMD    = 14'h000,
        PRMD    = 14'h001,
        ECFG    = 14'h004,
        ESTAT   = 14'h005,
        ERA     = 14'h006,
        BADV    = 14'h007,
        EENTRY  = 14'h00C,
        SAVE0   = 14'h030,
        SAVE1   = 14'h031,
        SAVE2   = 14'h032,
        SAVE3   = 14'h033,
        TID     = 14'h040,
        TCFG    = 14'h041,
        TVAL    = 14'h042,
        TICLR   = 14'h044,
        TIMER_L = 14'h060,
        TIMER_H = 14'h061
    } csr_addr_e;

    // Field positions below give the low bit of each field

    // CRMD
    localparam int CRMD_PLV  = 0;   // 1:0
    localparam int CRMD_IE   = 2;
    localparam int CRMD_DA   = 3;
    localparam int CRMD_PG   = 4;
    localparam int CRMD_DATF = 5;   // 6:5
    localparam int CRMD_DATM = 7;   // 8:7

    // PRMD
    localparam int PRMD_PPLV = 0;   // 1:0
    localparam int PRMD_PIE  = 2;

    // ESTAT
    localparam int ESTAT_IS_SOFT  = 0;   // 1:0
    localparam int ESTAT_IS_HARD  = 2;   // 9:2
    localparam int ESTAT_IS_TI    = 11;
    localparam int ESTAT_ECODE    = 16;  // 21:16
    localparam int ESTAT_ESUBCODE = 22;  // 30:22

    // Local interrupt enables, bits 9:0 and 12:11
    localparam logic [31:0] ECFG_LIE_MASK = 32'h0000_1BFF;

    // TCFG
    localparam int TCFG_EN       = 0;
    localparam int TCFG_PERIODIC = 1;
    localparam int TCFG_INITVAL  = 2;   // 31:2

    // Exception entry is 64-byte aligned
    localparam logic [31:0] EENTRY_MASK = 32'hFFFF_FFC0;

    // Direct address mode out of reset
    localparam logic [31:0] CRMD_RESET = 32'h0000_0008;

    localparam int HARD_IRQ_W = 8;

endpackage

// ==== rtl/csr_exc_ctrl.sv ====
`timescale 1ns/100ps

module csr_exc_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               csr_wen,
    input  csr_pkg::csr_addr_e csr_waddr,
    input  logic [31:0]        wdata,
    input  logic               in_excp,
    input  logic               is_etrn,
    input  logic [5:0]         excp_ecode,
    input  logic [8:0]         excp_subecode,
    input  logic [31:0]        excp_era,
    input  logic               use_badv,
    input  logic [31:0]        bad_vaddr,
    output logic [31:0]        crmd,
    output logic [31:0]        prmd,
    output logic [31:0]        era,
    output logic [31:0]        eentry,
    output logic [31:0]        badv,
    output logic [31:0]        estat_code,
    output logic               crmd_ie,
    output logic               excp_jump,
    output logic [31:0]        excp_pc,
    output logic               jump_excp_fail
);

    import csr_pkg::*;

    logic       crmd_wr;
    logic       prmd_wr;
    logic       era_wr;
    logic       eentry_wr;
    logic       excp_take;
    logic [5:0] ecode;
    logic [8:0] esubcode;

    assign crmd_wr   = csr_wen && (csr_waddr == CRMD);
    assign prmd_wr   = csr_wen && (csr_waddr == PRMD);
    assign era_wr    = csr_wen && (csr_waddr == ERA);
    assign eentry_wr = csr_wen && (csr_waddr == EENTRY);

    // Exception state only saved when no CSR write collides
    assign excp_take = in_excp && !csr_wen;

    assign jump_excp_fail = csr_wen && in_excp;
    assign excp_jump      = (in_excp || is_etrn) && !jump_excp_fail;
    // ertn forwards an ERA write from the same cycle
    assign excp_pc        = in_excp ? eentry : (era_wr ? wdata : era);
    assign crmd_ie        = crmd[CRMD_IE];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            crmd <= CRMD_RESET;
        end
        else if (crmd_wr)
        begin
            crmd[CRMD_PLV +: 2]  <= wdata[CRMD_PLV +: 2];
            crmd[CRMD_IE]        <= wdata[CRMD_IE];
            crmd[CRMD_DA]        <= wdata[CRMD_DA];
            crmd[CRMD_PG]        <= wdata[CRMD_PG];
            crmd[CRMD_DATF +: 2] <= wdata[CRMD_DATF +: 2];
            crmd[CRMD_DATM +: 2] <= wdata[CRMD_DATM +: 2];
        end
        else if (in_excp)
        begin
            crmd[CRMD_PLV +: 2] <= 2'b00;
            crmd[CRMD_IE]       <= 1'b0;
        end
        else if (is_etrn)
        begin
            crmd[CRMD_PLV +: 2] <= prmd[PRMD_PPLV +: 2];
            crmd[CRMD_IE]       <= prmd[PRMD_PIE];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            prmd <= '0;
        end
        else if (prmd_wr)
        begin
            prmd[PRMD_PPLV +: 2] <= wdata[PRMD_PPLV +: 2];
            prmd[PRMD_PIE]       <= wdata[PRMD_PIE];
        end
        else if (excp_take)
        begin
            prmd[PRMD_PPLV +: 2] <= crmd[CRMD_PLV +: 2];
            prmd[PRMD_PIE]       <= crmd[CRMD_IE];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            era      <= '0;
            eentry   <= '0;
            badv     <= '0;
            ecode    <= '0;
            esubcode <= '0;
        end
        else
        begin
            if (era_wr)
            begin
                era <= wdata;
            end
            else if (excp_take)
            begin
                era <= excp_era;
            end

            if (eentry_wr)
            begin
                eentry <= wdata & EENTRY_MASK;
            end

            if (in_excp && use_badv)
            begin
                badv <= bad_vaddr;
            end

            if (excp_take)
            begin
                ecode    <= excp_ecode;
                esubcode <= excp_subecode;
            end
        end
    end

    // ESTAT code fields in place, interrupt bits come from csr_intr
    always_comb
    begin
        estat_code = '0;
        estat_code[ESTAT_ECODE +: 6]    = ecode;
        estat_code[ESTAT_ESUBCODE +: 9] = esubcode;
    end

    // Decode never flags an exception on an ertn instruction
    assert property (@(posedge clk) disable iff (rst) !(in_excp && is_etrn))
        else $error("in_excp and is_etrn high together");

endmodule

// ==== rtl/csr_timer.sv ====
`timescale 1ns/100ps

module csr_timer #(
    parameter int TIMER_W = 64
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               csr_wen,
    input  csr_pkg::csr_addr_e csr_waddr,
    input  logic [31:0]        wdata,
    output logic [31:0]        tcfg,
    output logic [31:0]        tval,
    output logic [31:0]        timer_lo,
    output logic [31:0]        timer_hi,
    output logic               timer_fire
);

    import csr_pkg::*;

    logic               tcfg_wr;
    logic               timer_en;
    logic               tval_zero;
    logic [31:0]        reload_val;
    logic [TIMER_W-1:0] stable_cnt;

    assign tcfg_wr    = csr_wen && (csr_waddr == TCFG);
    assign tval_zero  = (tval == '0);
    assign reload_val = {tcfg[TCFG_INITVAL +: 30], 2'b00};
    assign timer_fire = timer_en && tval_zero;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tcfg     <= '0;
            timer_en <= 1'b0;
        end
        else if (tcfg_wr)
        begin
            tcfg     <= wdata;
            timer_en <= wdata[TCFG_EN];
        end
        else if (timer_fire)
        begin
            // One-shot mode stops here
            timer_en <= tcfg[TCFG_PERIODIC];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tval <= '0;
        end
        else if (tcfg_wr)
        begin
            tval <= {wdata[TCFG_INITVAL +: 30], 2'b00};
        end
        else if (timer_en)
        begin
            if (!tval_zero)
            begin
                tval <= tval - 32'd1;
            end
            else
            begin
                tval <= tcfg[TCFG_PERIODIC] ? reload_val : '0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            stable_cnt <= '0;
        end
        else
        begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

    assign timer_lo = stable_cnt[31:0];
    // Zero-extended above TIMER_W
    assign timer_hi = 32'(stable_cnt[TIMER_W-1:32]);

    // Countdown frozen while idle
    assert property (@(posedge clk) disable iff (rst)
        (!timer_en && !tcfg_wr) |=> $stable(tval))
        else $error("TVAL changed while timer disabled");

endmodule

// ==== rtl/csr_intr.sv ====
`timescale 1ns/100ps

module csr_intr (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          csr_wen,
    input  csr_pkg::csr_addr_e            csr_waddr,
    input  logic [31:0]                   wdata,
    input  logic [csr_pkg::HARD_IRQ_W-1:0] intrpt,
    input  logic                          timer_fire,
    input  logic                          crmd_ie,
    output logic [31:0]                   ecfg,
    output logic [31:0]                   estat_is,
    output logic                          have_intrpt
);

    import csr_pkg::*;

    logic                  ecfg_wr;
    logic                  estat_wr;
    logic                  ticlr_wr;
    logic [1:0]            is_soft;
    logic [HARD_IRQ_W-1:0] is_hard;
    logic                  is_ti;

    assign ecfg_wr  = csr_wen && (csr_waddr == ECFG);
    assign estat_wr = csr_wen && (csr_waddr == ESTAT);
    // TICLR bit 0 is the clear strobe
    assign ticlr_wr = csr_wen && (csr_waddr == TICLR) && wdata[0];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ecfg    <= '0;
            is_soft <= '0;
            is_hard <= '0;
            is_ti   <= 1'b0;
        end
        else
        begin
            if (ecfg_wr)
            begin
                ecfg <= wdata & ECFG_LIE_MASK;
            end
            if (estat_wr)
            begin
                is_soft <= wdata[ESTAT_IS_SOFT +: 2];
            end
            is_hard <= intrpt;
            // A fire in the same cycle beats the clear
            if (timer_fire)
            begin
                is_ti <= 1'b1;
            end
            else if (ticlr_wr)
            begin
                is_ti <= 1'b0;
            end
        end
    end

    always_comb
    begin
        estat_is = '0;
        estat_is[ESTAT_IS_SOFT +: 2]          = is_soft;
        estat_is[ESTAT_IS_HARD +: HARD_IRQ_W] = is_hard;
        estat_is[ESTAT_IS_TI]                 = is_ti;
    end

    assign have_intrpt = crmd_ie && (|(ecfg[12:0] & estat_is[12:0]));

    assert property (@(posedge clk) disable iff (rst) have_intrpt |-> crmd_ie)
        else $error("interrupt request with CRMD.IE clear");

endmodule

// ==== rtl/csr_scratch.sv ====
`timescale 1ns/100ps

module csr_scratch (
    input  logic               clk,
    input  logic               rst,
    input  logic               csr_wen,
    input  csr_pkg::csr_addr_e csr_waddr,
    input  logic [31:0]        wdata,
    output logic [31:0]        save0,
    output logic [31:0]        save1,
    output logic [31:0]        save2,
    output logic [31:0]        save3,
    output logic [31:0]        tid
);

    import csr_pkg::*;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            save0 <= '0;
            save1 <= '0;
            save2 <= '0;
            save3 <= '0;
            tid   <= '0;
        end
        else if (csr_wen)
        begin
            case (csr_waddr)
                SAVE0:   save0 <= wdata;
                SAVE1:   save1 <= wdata;
                SAVE2:   save2 <= wdata;
                SAVE3:   save3 <= wdata;
                TID:     tid   <= wdata;
                default: ;
            endcase
        end
    end

endmodule

// ==== rtl/csr_read_mux.sv ====
`timescale 1ns/100ps

module csr_read_mux (
    input  logic [13:0] csr_addr1,
    input  logic [13:0] csr_addr2,
    input  logic [31:0] crmd,
    input  logic [31:0] prmd,
    input  logic [31:0] era,
    input  logic [31:0] eentry,
    input  logic [31:0] badv,
    input  logic [31:0] estat_code,
    input  logic [31:0] estat_is,
    input  logic [31:0] ecfg,
    input  logic [31:0] tcfg,
    input  logic [31:0] tval,
    input  logic [31:0] timer_lo,
    input  logic [31:0] timer_hi,
    input  logic [31:0] save0,
    input  logic [31:0] save1,
    input  logic [31:0] save2,
    input  logic [31:0] save3,
    input  logic [31:0] tid,
    output logic [31:0] csr_data1,
    output logic [31:0] csr_data2
);

    import csr_pkg::*;

    logic [31:0] estat;

    // Code and interrupt halves never overlap
    assign estat = estat_code | estat_is;

    function automatic logic [31:0] read_csr(input logic [13:0] addr);
        logic [31:0] val;
        case (addr)
            CRMD:    val = crmd;
            PRMD:    val = prmd;
            ECFG:    val = ecfg;
            ESTAT:   val = estat;
            ERA:     val = era;
            BADV:    val = badv;
            EENTRY:  val = eentry;
            SAVE0:   val = save0;
            SAVE1:   val = save1;
            SAVE2:   val = save2;
            SAVE3:   val = save3;
            TID:     val = tid;
            TCFG:    val = tcfg;
            TVAL:    val = tval;
            TIMER_L: val = timer_lo;
            TIMER_H: val = timer_hi;
            default: val = '0;
        endcase
        return val;
    endfunction

    always_comb
    begin
        csr_data1 = read_csr(csr_addr1);
        csr_data2 = read_csr(csr_addr2);
    end

endmodule

// ==== rtl/csr_top.sv ====
`timescale 1ns/100ps

module csr_top #(
    parameter int TIMER_W = 64
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [13:0]                    csr_addr1,
    input  logic [13:0]                    csr_addr2,
    output logic [31:0]                    csr_data1,
    output logic [31:0]                    csr_data2,
    input  logic                           csr_wen,
    input  csr_pkg::csr_addr_e             csr_waddr,
    input  logic [31:0]                    wdata,
    input  logic                           in_excp,
    input  logic                           is_etrn,
    input  logic [5:0]                     excp_ecode,
    input  logic [8:0]                     excp_subecode,
    input  logic [31:0]                    excp_era,
    input  logic                           use_badv,
    input  logic [31:0]                    bad_vaddr,
    input  logic [csr_pkg::HARD_IRQ_W-1:0] intrpt,
    output logic                           excp_jump,
    output logic [31:0]                    excp_pc,
    output logic                           jump_excp_fail,
    output logic                           have_intrpt
);

    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] era;
    logic [31:0] eentry;
    logic [31:0] badv;
    logic [31:0] estat_code;
    logic [31:0] estat_is;
    logic [31:0] ecfg;
    logic [31:0] tcfg;
    logic [31:0] tval;
    logic [31:0] timer_lo;
    logic [31:0] timer_hi;
    logic [31:0] save0;
    logic [31:0] save1;
    logic [31:0] save2;
    logic [31:0] save3;
    logic [31:0] tid;
    logic        crmd_ie;
    logic        timer_fire;

    // Block port names match the nets here
    csr_exc_ctrl u_exc_ctrl (.*);

    csr_timer #(
        .TIMER_W(TIMER_W)
    ) u_timer (.*);

    csr_intr u_intr (.*);

    csr_scratch u_scratch (.*);

    csr_read_mux u_read_mux (.*);

endmodule

// ==== tests/csr_top_tb.sv ====
`timescale 1ns/100ps

module csr_top_tb;

    import csr_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 5;
    localparam int WAIT_MAX     = 20;
    // Two timer waits in the table
    localparam int TIMER_WAIT   = 2 * WAIT_MAX;
    localparam int MARGIN_NS    = 200;

    // Expected flags: jump, fail, interrupt request
    localparam logic [2:0] F_NONE = 3'b000;
    localparam logic [2:0] F_IRQ  = 3'b001;
    localparam logic [2:0] F_FAIL = 3'b010;
    localparam logic [2:0] F_JUMP = 3'b100;

    localparam logic [5:0]  EXC_CODE  = 6'h0B;
    localparam logic [8:0]  EXC_SUB   = 9'h005;
    localparam logic [31:0] BAD_VA    = 32'h0BAD_0ACC;
    localparam logic [13:0] NO_CSR    = 14'h7FF;
    localparam logic [31:0] ESTAT_EXC = (32'(EXC_SUB) << ESTAT_ESUBCODE)
                                      | (32'(EXC_CODE) << ESTAT_ECODE);
    localparam logic [31:0] TI_BIT    = 32'h1 << ESTAT_IS_TI;

    typedef enum logic [2:0] {
        OP_IDLE, OP_WRITE, OP_EXCP, OP_EXCP_WR, OP_ERTN, OP_ERTN_WR, OP_IRQ, OP_WAIT_TI
    } op_e;

    typedef enum logic [1:0] {CMP_EXACT, CMP_SNAP, CMP_DELTA} cmp_e;

    typedef struct packed {
        int          test;
        op_e         op;
        csr_addr_e   waddr;
        logic [31:0] wdata;
        logic [31:0] aux;
        logic [13:0] addr1;
        logic [13:0] addr2;
        logic [31:0] exp1;
        logic [31:0] exp2;
        logic [2:0]  flags;
        logic [31:0] exp_pc;
        cmp_e        cmp;
    } step_t;

    logic                  clk;
    logic                  rst;
    logic [13:0]           csr_addr1;
    logic [13:0]           csr_addr2;
    logic [31:0]           csr_data1;
    logic [31:0]           csr_data2;
    logic                  csr_wen;
    csr_addr_e             csr_waddr;
    logic [31:0]           wdata;
    logic                  in_excp;
    logic                  is_etrn;
    logic [5:0]            excp_ecode;
    logic [8:0]            excp_subecode;
    logic [31:0]           excp_era;
    logic                  use_badv;
    logic [31:0]           bad_vaddr;
    logic [HARD_IRQ_W-1:0] intrpt;
    logic                  excp_jump;
    logic [31:0]           excp_pc;
    logic                  jump_excp_fail;
    logic                  have_intrpt;

    step_t       steps[$];
    int          cur_test;
    string       test_names[1:6];
    int          test_errors[1:6];
    int          errors;
    logic [31:0] rnd[5];
    logic [31:0] snap;
    logic [31:0] next_aux;
    logic [31:0] next_pc;
    cmp_e        next_cmp;
    logic        jump_pre;
    logic        fail_pre;
    logic [31:0] pc_pre;

    csr_top #(
        .TIMER_W(64)
    ) DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic begin_test(input int n, input string name);
        cur_test      = n;
        test_names[n] = name;
    endtask

    // Wait count or exception ERA, jump target and compare mode for the next step
    task automatic set_extras(input logic [31:0] aux, input logic [31:0] pc, input cmp_e cmp);
        next_aux = aux;
        next_pc  = pc;
        next_cmp = cmp;
    endtask

    task automatic add_step(input op_e op, input csr_addr_e waddr, input logic [31:0] wd,
                            input logic [13:0] a1, input logic [13:0] a2,
                            input logic [31:0] e1, input logic [31:0] e2,
                            input logic [2:0] flags);
        step_t s;
        s.test   = cur_test;
        s.op     = op;
        s.waddr  = waddr;
        s.wdata  = wd;
        s.aux    = next_aux;
        s.addr1  = a1;
        s.addr2  = a2;
        s.exp1   = e1;
        s.exp2   = e2;
        s.flags  = flags;
        s.exp_pc = next_pc;
        s.cmp    = next_cmp;
        steps.push_back(s);
        set_extras('0, '0, CMP_EXACT);
    endtask

    task automatic build_table();
        set_extras('0, '0, CMP_EXACT);
        begin_test(1, "reset values");
        add_step(OP_IDLE, CRMD, 0, CRMD, CRMD, CRMD_RESET, CRMD_RESET, F_NONE);
        add_step(OP_IDLE, CRMD, 0, PRMD, ESTAT, 0, 0, F_NONE);
        add_step(OP_IDLE, CRMD, 0, ERA, BADV, 0, 0, F_NONE);
        add_step(OP_IDLE, CRMD, 0, EENTRY, ECFG, 0, 0, F_NONE);
        add_step(OP_IDLE, CRMD, 0, SAVE0, TID, 0, 0, F_NONE);
        add_step(OP_IDLE, CRMD, 0, SAVE1, SAVE2, 0, 0, F_NONE);
        add_step(OP_IDLE, CRMD, 0, SAVE3, TICLR, 0, 0, F_NONE);
        add_step(OP_IDLE, CRMD, 0, TCFG, TVAL, 0, 0, F_NONE);
        add_step(OP_IDLE, CRMD, 0, TIMER_H, NO_CSR, 0, 0, F_NONE);

        begin_test(2, "writes and masks");
        add_step(OP_WRITE, SAVE0, rnd[0], SAVE0, SAVE0, rnd[0], rnd[0], F_NONE);
        add_step(OP_WRITE, SAVE1, rnd[1], SAVE1, SAVE0, rnd[1], rnd[0], F_NONE);
        add_step(OP_WRITE, SAVE2, rnd[2], SAVE2, SAVE1, rnd[2], rnd[1], F_NONE);
        add_step(OP_WRITE, SAVE3, rnd[3], SAVE3, TID, rnd[3], 0, F_NONE);
        add_step(OP_WRITE, TID, rnd[4], TID, SAVE2, rnd[4], rnd[2], F_NONE);
        add_step(OP_WRITE, EENTRY, '1, EENTRY, CRMD, 32'hFFFF_FFC0, CRMD_RESET, F_NONE);
        add_step(OP_WRITE, ECFG, '1, ECFG, ESTAT, 32'h0000_1BFF, 0, F_NONE);
        add_step(OP_WRITE, ESTAT, '1, ESTAT, ECFG, 32'h3, 32'h0000_1BFF, F_NONE);
        add_step(OP_WRITE, ESTAT, 0, ESTAT, SAVE3, 0, rnd[3], F_NONE);
        add_step(OP_WRITE, ECFG, 0, ECFG, SAVE1, 0, rnd[1], F_NONE);

        begin_test(3, "exception entry");
        add_step(OP_WRITE, EENTRY, 32'h1C00_0040, EENTRY, CRMD, 32'h1C00_0040, CRMD_RESET,
                 F_NONE);
        // PLV 3 with IE set
        add_step(OP_WRITE, CRMD, 32'h7, CRMD, PRMD, 32'h7, 0, F_NONE);
        set_extras(32'h1C00_1234, 32'h1C00_0040, CMP_EXACT);
        add_step(OP_EXCP, CRMD, 0, CRMD, PRMD, 0, 32'h7, F_JUMP);
        add_step(OP_IDLE, CRMD, 0, ERA, BADV, 32'h1C00_1234, BAD_VA, F_NONE);
        add_step(OP_IDLE, CRMD, 0, ESTAT, CRMD, ESTAT_EXC, 0, F_NONE);
        // Colliding write wins, ERA keeps the earlier value
        set_extras(32'hDEAD_0000, '0, CMP_EXACT);
        add_step(OP_EXCP_WR, SAVE0, 32'h5A5A_5A5A, ERA, SAVE0, 32'h1C00_1234, 32'h5A5A_5A5A,
                 F_FAIL);
        add_step(OP_IDLE, CRMD, 0, PRMD, ESTAT, 32'h7, ESTAT_EXC, F_NONE);

        begin_test(4, "ertn");
        set_extras('0, 32'h1C00_1234, CMP_EXACT);
        add_step(OP_ERTN, CRMD, 0, CRMD, ERA, 32'h7, 32'h1C00_1234, F_JUMP);
        set_extras('0, 32'h1C00_2000, CMP_EXACT);
        add_step(OP_ERTN_WR, ERA, 32'h1C00_2000, ERA, CRMD, 32'h1C00_2000, 32'h7, F_JUMP);
        add_step(OP_WRITE, PRMD, 32'h1, PRMD, CRMD, 32'h1, 32'h7, F_NONE);
        set_extras('0, 32'h1C00_2000, CMP_EXACT);
        add_step(OP_ERTN, CRMD, 0, CRMD, PRMD, 32'h1, 32'h1, F_JUMP);
        add_step(OP_WRITE, CRMD, 32'h4, CRMD, ECFG, 32'h4, 0, F_NONE);

        begin_test(5, "timer");
        add_step(OP_WRITE, ECFG, TI_BIT, ECFG, ESTAT, TI_BIT, ESTAT_EXC, F_NONE);
        // One-shot, InitVal 2
        add_step(OP_WRITE, TCFG, 32'h9, TCFG, TVAL, 32'h9, 32'd8, F_NONE);
        add_step(OP_IDLE, CRMD, 0, TVAL, TCFG, 32'd7, 32'h9, F_NONE);
        add_step(OP_IDLE, CRMD, 0, TVAL, TCFG, 32'd6, 32'h9, F_NONE);
        set_extras(32'd7, '0, CMP_EXACT);
        add_step(OP_WAIT_TI, CRMD, 0, ESTAT, TVAL, ESTAT_EXC | TI_BIT, 0, F_IRQ);
        add_step(OP_IDLE, CRMD, 0, TVAL, TCFG, 0, 32'h9, F_IRQ);
        add_step(OP_WRITE, TICLR, 32'h1, ESTAT, TVAL, ESTAT_EXC, 0, F_NONE);
        // Periodic, InitVal 2
        add_step(OP_WRITE, TCFG, 32'hB, TVAL, TCFG, 32'd8, 32'hB, F_NONE);
        set_extras(32'd9, '0, CMP_EXACT);
        add_step(OP_WAIT_TI, CRMD, 0, ESTAT, TVAL, ESTAT_EXC | TI_BIT, 32'd8, F_IRQ);
        add_step(OP_IDLE, CRMD, 0, TVAL, ESTAT, 32'd7, ESTAT_EXC | TI_BIT, F_IRQ);
        add_step(OP_WRITE, TCFG, 0, TVAL, TCFG, 0, 0, F_IRQ);
        add_step(OP_WRITE, TICLR, 32'h1, ESTAT, TVAL, ESTAT_EXC, 0, F_NONE);

        begin_test(6, "hardware interrupts and stable counter");
        add_step(OP_IRQ, CRMD, 32'hA5, ESTAT, ECFG, ESTAT_EXC | (32'hA5 << ESTAT_IS_HARD),
                 TI_BIT, F_NONE);
        add_step(OP_WRITE, ECFG, 32'h4, ECFG, ESTAT, 32'h4, ESTAT_EXC | (32'hA5 << ESTAT_IS_HARD),
                 F_IRQ);
        add_step(OP_IRQ, CRMD, 0, ESTAT, ECFG, ESTAT_EXC, 32'h4, F_NONE);
        set_extras('0, '0, CMP_SNAP);
        add_step(OP_IDLE, CRMD, 0, TIMER_L, TIMER_H, 0, 0, F_NONE);
        add_step(OP_IDLE, CRMD, 0, TIMER_H, SAVE0, 0, 32'h5A5A_5A5A, F_NONE);
        add_step(OP_IDLE, CRMD, 0, TIMER_H, SAVE0, 0, 32'h5A5A_5A5A, F_NONE);
        set_extras('0, '0, CMP_DELTA);
        add_step(OP_IDLE, CRMD, 0, TIMER_L, TIMER_H, 32'd3, 0, F_NONE);
    endtask

    task automatic drive_step(input step_t s);
        csr_wen       = (s.op == OP_WRITE) || (s.op == OP_EXCP_WR) || (s.op == OP_ERTN_WR);
        in_excp       = (s.op == OP_EXCP) || (s.op == OP_EXCP_WR);
        is_etrn       = (s.op == OP_ERTN) || (s.op == OP_ERTN_WR);
        csr_waddr     = s.waddr;
        wdata         = s.wdata;
        csr_addr1     = s.addr1;
        csr_addr2     = s.addr2;
        excp_ecode    = in_excp ? EXC_CODE : '0;
        excp_subecode = in_excp ? EXC_SUB : '0;
        excp_era      = in_excp ? s.aux : '0;
        use_badv      = in_excp;
        bad_vaddr     = in_excp ? BAD_VA : '0;
        // Interrupt lines hold until the next OP_IRQ step
        if (s.op == OP_IRQ)
        begin
            intrpt = s.wdata[HARD_IRQ_W-1:0];
        end
    endtask

    task automatic count_error(input int t);
        errors++;
        test_errors[t]++;
    endtask

    task automatic mismatch(input int idx, input int t, input string what,
                            input logic [31:0] got, input logic [31:0] want);
        $display("FAIL %0t: step %0d %s is %h, expected %h", $time, idx, what, got, want);
        count_error(t);
    endtask

    task automatic check_step(input int idx, input step_t s);
        logic [31:0] want1;
        want1 = s.exp1;
        if (s.cmp == CMP_DELTA)
        begin
            want1 = snap + s.exp1;
        end
        if (s.cmp == CMP_SNAP)
        begin
            snap = csr_data1;
        end
        else if (csr_data1 !== want1)
        begin
            mismatch(idx, s.test, "csr_data1", csr_data1, want1);
        end
        if (csr_data2 !== s.exp2)
        begin
            mismatch(idx, s.test, "csr_data2", csr_data2, s.exp2);
        end
        if (jump_pre !== s.flags[2])
        begin
            mismatch(idx, s.test, "excp_jump", jump_pre, s.flags[2]);
        end
        if (fail_pre !== s.flags[1])
        begin
            mismatch(idx, s.test, "jump_excp_fail", fail_pre, s.flags[1]);
        end
        if (have_intrpt !== s.flags[0])
        begin
            mismatch(idx, s.test, "have_intrpt", have_intrpt, s.flags[0]);
        end
        if (s.flags[2] && pc_pre !== s.exp_pc)
        begin
            mismatch(idx, s.test, "excp_pc", pc_pre, s.exp_pc);
        end
    endtask

    initial
    begin
        step_t s;
        int    cnt;
        int    bad_tests;
        clk           = 1'b0;
        rst           = 1'b1;
        csr_addr1     = '0;
        csr_addr2     = '0;
        csr_wen       = 1'b0;
        csr_waddr     = CRMD;
        wdata         = '0;
        in_excp       = 1'b0;
        is_etrn       = 1'b0;
        excp_ecode    = '0;
        excp_subecode = '0;
        excp_era      = '0;
        use_badv      = 1'b0;
        bad_vaddr     = '0;
        intrpt        = '0;
        errors        = 0;
        bad_tests     = 0;
        snap          = '0;
        for (int t = 1; t <= 6; t++)
        begin
            test_errors[t] = 0;
        end
        void'($urandom(32'haaf2852e));
        for (int k = 0; k < 5; k++)
        begin
            rnd[k] = $urandom();
        end
        build_table();

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < steps.size(); i++)
        begin
            s = steps[i];
            @(negedge clk);
            drive_step(s);
            // Jump outputs taken before the edge that can write ERA
            #1;
            jump_pre = excp_jump;
            fail_pre = jump_excp_fail;
            pc_pre   = excp_pc;
            @(posedge clk);
            #1;
            cnt = 1;
            if (s.op == OP_WAIT_TI)
            begin
                while (!csr_data1[ESTAT_IS_TI] && cnt < WAIT_MAX)
                begin
                    @(posedge clk);
                    #1;
                    cnt++;
                end
                if (!csr_data1[ESTAT_IS_TI])
                begin
                    $display("step %0d: timer interrupt never set within %0d cycles",
                             i, WAIT_MAX);
                    count_error(s.test);
                end
                else if (cnt != s.aux)
                begin
                    mismatch(i, s.test, "timer fire cycles", cnt, s.aux);
                end
            end
            check_step(i, s);
            if (i == steps.size() - 1 || steps[i + 1].test != s.test)
            begin
                $display("test %0d %s: %s, %0d errors", s.test, test_names[s.test],
                         (test_errors[s.test] == 0) ? "ok" : "bad", test_errors[s.test]);
                if (test_errors[s.test] != 0)
                begin
                    bad_tests++;
                end
            end
        end

        $display("steps %0d, errors %0d, tests with errors %0d", steps.size(), errors, bad_tests);
        if (errors == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial
    begin
        // Table is filled at time zero
        #1;
        #((steps.size() + TIMER_WAIT + RESET_CYCLES + 2) * CLK_PERIOD + MARGIN_NS);
        $display("watchdog expired before the stimulus table finished");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== csr_top.f ====
rtl/csr_pkg.sv
rtl/csr_exc_ctrl.sv
rtl/csr_timer.sv
rtl/csr_intr.sv
rtl/csr_scratch.sv
rtl/csr_read_mux.sv
rtl/csr_top.sv
tests/csr_top_tb.sv

// ==== Bender.yml ====
package:
  name: csr_top

sources:
  - files:
      - rtl/csr_pkg.sv
      - rtl/csr_exc_ctrl.sv
      - rtl/csr_timer.sv
      - rtl/csr_intr.sv
      - rtl/csr_scratch.sv
      - rtl/csr_read_mux.sv
      - rtl/csr_top.sv
  - target: test
    files:
      - tests/csr_top_tb.sv
